// File: logic/xfcp_macros.svh
// Bridge constants
`ifndef XFCP_MACROS_SVH
`define XFCP_MACROS_SVH

// Clock and serial line rate
`define XFCP_CLK_HZ 125000000
`define XFCP_BAUD 115200
`define XFCP_OVERSAMPLE 8

// Cycles per oversample tick
`define XFCP_PRESCALE (`XFCP_CLK_HZ / (`XFCP_BAUD * `XFCP_OVERSAMPLE))

// Command opcodes
`define XFCP_OP_WRITE 8'h01
`define XFCP_OP_READ 8'h02
// Set in the opcode to form the reply byte
`define XFCP_ACK_BIT 8'h80

`define XFCP_RAM_WORDS 256

`endif

// File: logic/xfcp_pkg.sv
// Bridge types
`default_nettype none

package xfcp_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  addr_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] prescale_t;

    // One UART byte with its strobe
    typedef struct packed {
        logic  valid;
        byte_t data;
    } uart_byte_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        word_t wdata;
    } ram_req_t;

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_ADDR,
        CMD_DATA,
        CMD_RAM,
        CMD_WAIT_RD,
        CMD_REPLY,
        CMD_SEND_WAIT
    } cmd_state_t;

endpackage

`default_nettype wire

// File: logic/baud_timer.sv
// Oversample tick generator
`default_nettype none

`include "xfcp_macros.svh"

module baud_timer #(
    parameter xfcp_pkg::prescale_t PRESCALE = xfcp_pkg::prescale_t'(`XFCP_PRESCALE)
) (
    input  wire  clk,
    input  wire  arst_n_i,
    output logic tick_o
);
    import xfcp_pkg::*;

    prescale_t count;

    // Free-running, one tick per reload
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count  <= '0;
            tick_o <= 1'b0;
        end else if (count == '0) begin
            count  <= prescale_t'(PRESCALE - 1'b1);
            tick_o <= 1'b1;
        end else begin
            count  <= count - 1'b1;
            tick_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/uart_rx.sv
// UART receiver, 8N1
`default_nettype none

`include "xfcp_macros.svh"

module uart_rx (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire                  tick_i,
    input  wire                  rxd_i,
    output xfcp_pkg::uart_byte_t rx_byte_o
);
    import xfcp_pkg::*;

    localparam logic [2:0] TICK_MID  = 3'(`XFCP_OVERSAMPLE / 2 - 1);
    localparam logic [2:0] TICK_LAST = 3'(`XFCP_OVERSAMPLE - 1);

    logic [2:0] sync_q;
    logic       rxd_s;
    logic       start_edge;
    logic       active;
    logic [2:0] tick_cnt;
    logic [3:0] bit_cnt;
    logic       sample;
    logic       valid_q;
    byte_t      shift_q;

    // Two synchronizer stages plus one for edge detect
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= 3'b111;
        end else begin
            sync_q <= {sync_q[1:0], rxd_i};
        end
    end

    assign rxd_s      = sync_q[1];
    assign start_edge = sync_q[2] & ~sync_q[1];
    assign sample     = active && tick_i && (tick_cnt == TICK_MID);

    // Bit 0 is the start bit, 9 the stop bit
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active   <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (!active) begin
                if (start_edge) begin
                    active   <= 1'b1;
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else if (tick_i) begin
                tick_cnt <= (tick_cnt == TICK_LAST) ? 3'd0 : tick_cnt + 3'd1;
                if (tick_cnt == TICK_LAST) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
                if (sample && bit_cnt == 4'd0 && rxd_s) begin
                    // Line went back high, not a real start bit
                    active <= 1'b0;
                end else if (sample && bit_cnt == 4'd9) begin
                    active  <= 1'b0;
                    valid_q <= rxd_s;
                end
            end
        end
    end

    // Data arrives LSB first
    always_ff @(posedge clk) begin
        if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
            shift_q <= {rxd_s, shift_q[7:1]};
        end
    end

    assign rx_byte_o.valid = valid_q;
    assign rx_byte_o.data  = shift_q;

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
// UART transmitter, 8N1
`default_nettype none

`include "xfcp_macros.svh"

module uart_tx (
    input  wire                       clk,
    input  wire                       arst_n_i,
    input  wire                       tick_i,
    input  wire xfcp_pkg::uart_byte_t tx_byte_i,
    output wire                       txd_o,
    output logic                      busy_o
);
    localparam logic [2:0] TICK_LAST = 3'(`XFCP_OVERSAMPLE - 1);

    logic [9:0] frame_q;
    logic [2:0] tick_cnt;
    logic [3:0] bit_cnt;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            frame_q  <= '1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            busy_o   <= 1'b0;
        end else if (!busy_o) begin
            if (tx_byte_i.valid) begin
                // Stop bit, data LSB first, start bit
                frame_q  <= {1'b1, tx_byte_i.data, 1'b0};
                tick_cnt <= '0;
                bit_cnt  <= '0;
                busy_o   <= 1'b1;
            end
        end else if (tick_i) begin
            tick_cnt <= (tick_cnt == TICK_LAST) ? 3'd0 : tick_cnt + 3'd1;
            if (tick_cnt == TICK_LAST) begin
                // Ones fill in behind, so the line idles high
                frame_q <= {1'b1, frame_q[9:1]};
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd9) begin
                    busy_o <= 1'b0;
                end
            end
        end
    end

    assign txd_o = frame_q[0];

endmodule

`default_nettype wire

// File: logic/cmd_fsm.sv
// Command parser and reply sequencer
`default_nettype none

`include "xfcp_macros.svh"

module cmd_fsm (
    input  wire                       clk,
    input  wire                       arst_n_i,
    input  wire xfcp_pkg::uart_byte_t rx_byte_i,
    input  wire                       tx_busy_i,
    input  wire xfcp_pkg::word_t      rdata_i,
    output xfcp_pkg::uart_byte_t      tx_byte_o,
    output xfcp_pkg::ram_req_t        ram_req_o
);
    import xfcp_pkg::*;

    cmd_state_t  state_q;
    byte_t       op_q;
    addr_t       addr_q;
    word_t       wdata_q;
    logic [1:0]  data_cnt;
    logic [2:0]  reply_left;
    logic [39:0] reply_q;
    logic        is_write;
    logic        known_op;
    logic        tx_fire;

    assign is_write = (op_q == `XFCP_OP_WRITE);
    assign known_op = (rx_byte_i.data == `XFCP_OP_WRITE) || (rx_byte_i.data == `XFCP_OP_READ);
    assign tx_fire  = (state_q == CMD_REPLY) && !tx_busy_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= CMD_IDLE;
            data_cnt   <= '0;
            reply_left <= '0;
        end else begin
            case (state_q)
                CMD_IDLE: begin
                    // Unknown opcodes are dropped here
                    if (rx_byte_i.valid && known_op) begin
                        state_q <= CMD_ADDR;
                    end
                end
                CMD_ADDR: begin
                    if (rx_byte_i.valid) begin
                        data_cnt <= '0;
                        state_q  <= is_write ? CMD_DATA : CMD_RAM;
                    end
                end
                CMD_DATA: begin
                    if (rx_byte_i.valid) begin
                        data_cnt <= data_cnt + 2'd1;
                        if (data_cnt == 2'd3) begin
                            state_q <= CMD_RAM;
                        end
                    end
                end
                CMD_RAM: begin
                    // Ack only for writes, ack plus word for reads
                    reply_left <= is_write ? 3'd1 : 3'd5;
                    state_q    <= is_write ? CMD_REPLY : CMD_WAIT_RD;
                end
                CMD_WAIT_RD: begin
                    state_q <= CMD_REPLY;
                end
                CMD_REPLY: begin
                    if (!tx_busy_i) begin
                        reply_left <= reply_left - 3'd1;
                        state_q    <= CMD_SEND_WAIT;
                    end
                end
                CMD_SEND_WAIT: begin
                    if (!tx_busy_i) begin
                        state_q <= (reply_left == 3'd0) ? CMD_IDLE : CMD_REPLY;
                    end
                end
                default: begin
                    state_q <= CMD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CMD_IDLE && rx_byte_i.valid) begin
            op_q <= rx_byte_i.data;
        end
        if (state_q == CMD_ADDR && rx_byte_i.valid) begin
            addr_q <= rx_byte_i.data;
        end
        // Write data comes MSB first
        if (state_q == CMD_DATA && rx_byte_i.valid) begin
            wdata_q <= {wdata_q[23:0], rx_byte_i.data};
        end
        if (state_q == CMD_RAM) begin
            reply_q <= {op_q | `XFCP_ACK_BIT, 32'h0};
        end else if (state_q == CMD_WAIT_RD) begin
            reply_q <= {op_q | `XFCP_ACK_BIT, rdata_i};
        end else if (tx_fire) begin
            reply_q <= {reply_q[31:0], 8'h00};
        end
    end

    assign tx_byte_o.valid = tx_fire;
    assign tx_byte_o.data  = reply_q[39:32];

    assign ram_req_o.valid = (state_q == CMD_RAM);
    assign ram_req_o.we    = is_write;
    assign ram_req_o.addr  = addr_q;
    assign ram_req_o.wdata = wdata_q;

endmodule

`default_nettype wire

// File: logic/word_ram.sv
// Word RAM with registered read
`default_nettype none

`include "xfcp_macros.svh"

module word_ram (
    input  wire                     clk,
    input  wire xfcp_pkg::ram_req_t ram_req_i,
    output xfcp_pkg::word_t         rdata_o
);
    import xfcp_pkg::*;

    word_t mem [`XFCP_RAM_WORDS];

    // Read data valid the cycle after a read strobe
    always_ff @(posedge clk) begin
        if (ram_req_i.valid) begin
            if (ram_req_i.we) begin
                mem[ram_req_i.addr] <= ram_req_i.wdata;
            end else begin
                rdata_o <= mem[ram_req_i.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/uart_ram_bridge.sv
// UART to RAM command bridge
`default_nettype none

`include "xfcp_macros.svh"

module uart_ram_bridge #(
    parameter xfcp_pkg::prescale_t PRESCALE = xfcp_pkg::prescale_t'(`XFCP_PRESCALE)
) (
    input  wire clk,
    input  wire arst_n_i,
    input  wire uart_rxd_i,
    output wire uart_txd_o
);
    import xfcp_pkg::*;

    logic       tick;
    uart_byte_t rx_byte;
    uart_byte_t tx_byte;
    logic       tx_busy;
    ram_req_t   ram_req;
    word_t      rdata;

    baud_timer #(
        .PRESCALE(PRESCALE)
    ) baud_timer_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .tick_o(tick)
    );

    uart_rx uart_rx_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .tick_i(tick),
        .rxd_i(uart_rxd_i),
        .rx_byte_o(rx_byte)
    );

    uart_tx uart_tx_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .tick_i(tick),
        .tx_byte_i(tx_byte),
        .txd_o(uart_txd_o),
        .busy_o(tx_busy)
    );

    cmd_fsm cmd_fsm_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .rx_byte_i(rx_byte),
        .tx_busy_i(tx_busy),
        .rdata_i(rdata),
        .tx_byte_o(tx_byte),
        .ram_req_o(ram_req)
    );

    word_ram word_ram_inst (
        .clk(clk),
        .ram_req_i(ram_req),
        .rdata_o(rdata)
    );

endmodule

`default_nettype wire

// File: bench/bridge_checker.sv
// Bridge protocol assertions
`default_nettype none

module bridge_checker (
    input wire                       clk,
    input wire                       arst_n_i,
    input wire                       rx_valid_i,
    input wire                       tx_valid_i,
    input wire                       tx_busy_i,
    input wire                       txd_i,
    input wire                       ram_valid_i,
    input wire                       ram_we_i,
    input wire xfcp_pkg::cmd_state_t state_i
);
    import xfcp_pkg::*;

    rx_single_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        rx_valid_i |=> !rx_valid_i)
        else $error("rx valid strobe lasted two cycles");

    // Strobe only while idle, and the transmitter takes it
    tx_start_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        tx_valid_i |=> (tx_busy_i && !$past(tx_busy_i)))
        else $error("tx strobe while busy or not accepted");

    // Line idles high between frames
    txd_idle_high: assert property (@(posedge clk) disable iff (!arst_n_i)
        !tx_busy_i |-> txd_i)
        else $error("txd low while transmitter idle");

    // Writes follow the last data byte
    ram_write_state: assert property (@(posedge clk) disable iff (!arst_n_i)
        (ram_valid_i && ram_we_i) |-> (state_i == CMD_RAM) && ($past(state_i) == CMD_DATA))
        else $error("RAM write outside CMD_RAM");

endmodule

bind uart_ram_bridge bridge_checker checker_inst (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .rx_valid_i(rx_byte.valid),
    .tx_valid_i(tx_byte.valid),
    .tx_busy_i(tx_busy),
    .txd_i(uart_txd_o),
    .ram_valid_i(ram_req.valid),
    .ram_we_i(ram_req.we),
    .state_i(cmd_fsm_inst.state_q)
);

`default_nettype wire

// File: bench/bridge_tb.sv
// Bridge directed testbench
`default_nettype none

`include "xfcp_macros.svh"

module bridge_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int PRESCALE    = 4;
    localparam int BIT_CYCLES  = PRESCALE * `XFCP_OVERSAMPLE;
    localparam int BYTE_CYCLES = 10 * BIT_CYCLES;
    localparam int NUM_CMDS    = 21;
    // 40 byte-times per command plus two silence windows of 20
    localparam int WATCHDOG_TIME = (NUM_CMDS * 40 + 40) * BYTE_CYCLES * CLK_PERIOD;

    // Reply bytes as given by the command format
    localparam logic [7:0] ACK_WRITE = 8'h81;
    localparam logic [7:0] ACK_READ  = 8'h82;

    logic       clk;
    logic       arst_n_i;
    logic       uart_rxd_i;
    wire        uart_txd_o;
    logic [7:0] rx_queue [$];

    uart_ram_bridge #(
        .PRESCALE(16'(PRESCALE))
    ) DUT (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .uart_rxd_i(uart_rxd_i),
        .uart_txd_o(uart_txd_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // 8N1 frame with an optional low stop bit and one idle bit after it
    task automatic send_byte(input logic [7:0] data, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, data, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            uart_rxd_i = frame[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        if (bad_stop) begin
            uart_rxd_i = 1'b1;
            repeat (BIT_CYCLES) @(negedge clk);
        end
    endtask

    // Samples each bit at mid-bit from the start edge
    task automatic recv_byte(output logic [7:0] data);
        data = '0;
        @(negedge clk);
        while (uart_txd_o !== 1'b0) @(negedge clk);
        repeat (BIT_CYCLES / 2) @(negedge clk);
        if (uart_txd_o !== 1'b0) begin
            $display("Start bit on uart_txd_o ended too early");
            stop_on_error();
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            data[i] = uart_txd_o;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        if (uart_txd_o !== 1'b1) begin
            $display("Stop bit on uart_txd_o was low");
            stop_on_error();
        end
    endtask

    task automatic expect_byte(input string name, input logic [7:0] expected);
        int         waited;
        logic [7:0] got;
        waited = 0;
        while (rx_queue.size() == 0 && waited < 3 * BYTE_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (rx_queue.size() == 0) begin
            $display("No reply byte arrived in test %s", name);
            stop_on_error();
        end
        got = rx_queue.pop_front();
        check(name, 32'(expected), 32'(got));
    endtask

    task automatic expect_silence(input string name, input int byte_times);
        repeat (byte_times * BYTE_CYCLES) begin
            @(negedge clk);
            check(name, 32'd1, 32'(uart_txd_o));
        end
        check(name, 32'd0, 32'(rx_queue.size()));
    endtask

    task automatic write_word(input string name, input logic [7:0] addr,
                              input logic [31:0] data);
        send_byte(`XFCP_OP_WRITE, 1'b0);
        send_byte(addr, 1'b0);
        for (int i = 3; i >= 0; i--) begin
            send_byte(data[8*i +: 8], 1'b0);
        end
        expect_byte(name, ACK_WRITE);
    endtask

    task automatic read_word(input string name, input logic [7:0] addr,
                             input logic [31:0] expected);
        send_byte(`XFCP_OP_READ, 1'b0);
        send_byte(addr, 1'b0);
        expect_byte(name, ACK_READ);
        for (int i = 3; i >= 0; i--) begin
            expect_byte(name, expected[8*i +: 8]);
        end
    endtask

    task automatic idle_after_reset();
        expect_silence("idle_after_reset", 20);
    endtask

    task automatic write_then_read();
        write_word("write_read", 8'h10, 32'hDEADBEEF);
        read_word("write_read", 8'h10, 32'hDEADBEEF);
    endtask

    task automatic random_writes();
        logic [7:0]  addrs [5];
        logic [31:0] words [5];
        logic        fresh;
        int          n;
        n = 0;
        while (n < 5) begin
            addrs[n] = 8'($urandom());
            fresh = 1'b1;
            for (int j = 0; j < n; j++) begin
                if (addrs[j] == addrs[n]) begin
                    fresh = 1'b0;
                end
            end
            if (fresh) begin
                words[n] = $urandom();
                write_word("random_writes", addrs[n], words[n]);
                n++;
            end
        end
        for (int k = 4; k >= 0; k--) begin
            read_word("random_writes", addrs[k], words[k]);
        end
    endtask

    task automatic overwrite_word();
        write_word("overwrite", 8'hA5, 32'h11223344);
        write_word("overwrite", 8'hA5, 32'hCAFEF00D);
        read_word("overwrite", 8'hA5, 32'hCAFEF00D);
    endtask

    task automatic unknown_opcode();
        write_word("unknown_opcode", 8'h5A, 32'h0BADC0DE);
        send_byte(8'h33, 1'b0);
        expect_silence("unknown_opcode", 20);
        read_word("unknown_opcode", 8'h5A, 32'h0BADC0DE);
    endtask

    // A read opcode with a bad stop bit must not start a command
    task automatic framing_error();
        write_word("framing_error", 8'hFF, 32'h76543210);
        send_byte(`XFCP_OP_READ, 1'b1);
        read_word("framing_error", 8'hFF, 32'h76543210);
    endtask

    // Collects every reply byte the bridge sends
    initial begin
        logic [7:0] b;
        @(posedge arst_n_i);
        forever begin
            recv_byte(b);
            rx_queue.push_back(b);
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout, the bridge did not finish the tests in time");
        stop_on_error();
    end

    initial begin
        arst_n_i   = 1'b0;
        uart_rxd_i = 1'b1;
        void'($urandom(83));
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;

        idle_after_reset();
        write_then_read();
        random_writes();
        overwrite_word();
        unknown_opcode();
        framing_error();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/xfcp_pkg.sv
logic/baud_timer.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_fsm.sv
logic/word_ram.sv
logic/uart_ram_bridge.sv
bench/bridge_checker.sv
bench/bridge_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = bridge_tb
FILELIST = files.f
OBJ_DIR  = obj_dir
PASS_MSG = ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
